// File: hdl/fmCart_config.svh
/* FM cartridge constants
   Bus addresses, SRAM key bytes and audio filter settings */

`ifndef FM_CART_CONFIG_SVH
`define FM_CART_CONFIG_SVH

// Bus widths
`define FM_ADDR_W           16
`define FM_DATA_W           8

// Address map
`define FM_IO_BASE          16'h007C    // I/O ports 7Ch-7Dh
`define FM_MIO_BASE         16'h7FF4    // Memory mapped synth 7FF4h-7FF5h
`define FM_IOSW_ADDR        16'h7FF6    // I/O switch register
`define FM_SRAM_BASE        16'h4000    // SRAM window 4000h-5FFFh
`define FM_SRAM_BANK_ADDR   16'h5FFE    // Enable registers 5FFEh-5FFFh

// SRAM enable key
`define FM_SRAM_KEY0        8'h4D
`define FM_SRAM_KEY1        8'h69

// Audio path
`define FM_SAMPLE_W         10          // Synth DAC width
`define FM_SAMPLE_OFFSET    512         // Unsigned midpoint
`define FM_LPF_PERIOD       18          // Moving average taps
`define FM_LPF_DIV          4           // Filter runs on every 4th enable
`define FM_LPF_SHIFT        4           // Gain 1/16

`endif

// File: hdl/fmCartPkg.sv
/* FM cartridge shared types
   Bus vectors, sample formats and the slot bus request */

`include "fmCart_config.svh"

package fmCartPkg;

    // Slot bus vectors
    typedef logic [`FM_ADDR_W-1:0] addr_t;
    typedef logic [`FM_DATA_W-1:0] busData_t;

    // Raw synth output, offset binary
    typedef logic [`FM_SAMPLE_W-1:0] sample_t;

    // Audio after offset removal
    typedef logic signed [`FM_SAMPLE_W-1:0] audio_t;

    // Filter running sum, room for 18 taps
    typedef logic signed [`FM_SAMPLE_W+4:0] lpfAcc_t;

    // Slot bus as seen from the cartridge, all strobes active low
    typedef struct packed {
        addr_t    addr;     // A15-A0
        busData_t wrData;   // Data from CPU
        logic     rd_n;
        logic     wr_n;
        logic     iorq_n;
        logic     merq_n;
        logic     sltsl_n;  // Slot select
    } busReq_t;

endpackage

// File: hdl/satLimiter.sv
/* Registered signed saturation to a narrower width */

module satLimiter #(
    parameter int IN_WIDTH  = 11,
    parameter int OUT_WIDTH = 10
) (
    input  logic                        CLK,
    input  logic                        RESET_n,
    input  logic signed [IN_WIDTH-1:0]  i_in,
    output logic signed [OUT_WIDTH-1:0] o_out
);
    logic                        inRange;
    logic signed [OUT_WIDTH-1:0] clamped;

    // Fits when all bits from the output sign upward agree
    assign inRange = (&i_in[IN_WIDTH-1:OUT_WIDTH-1]) | ~(|i_in[IN_WIDTH-1:OUT_WIDTH-1]);

    always_comb begin
        if (inRange)             clamped = i_in[OUT_WIDTH-1:0];
        else if (i_in[IN_WIDTH-1]) clamped = {1'b1, {(OUT_WIDTH-1){1'b0}}};  // Most negative
        else                     clamped = {1'b0, {(OUT_WIDTH-1){1'b1}}};  // Most positive
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) o_out <= '0;
        else          o_out <= clamped;
    end

endmodule

// File: hdl/movingAverageLpf.sv
/* Moving average low-pass filter
   18 taps on every 4th sample enable, gain 1/16, saturated output */

`include "fmCart_config.svh"

module movingAverageLpf (
    input  logic              CLK,
    input  logic              RESET_n,
    input  logic              i_sampleEn,
    input  fmCartPkg::audio_t i_in,
    output fmCartPkg::audio_t o_out
);
    localparam int PERIOD = `FM_LPF_PERIOD;
    localparam int IDX_W  = $clog2(PERIOD + 1);
    localparam int DIV_W  = $clog2(`FM_LPF_DIV);

    logic [DIV_W-1:0] divCnt;
    logic [IDX_W-1:0] index;        // Oldest entry, next to overwrite
    logic [IDX_W-1:0] fillCount;
    logic             tick;

    fmCartPkg::audio_t  window [0:PERIOD-1];
    fmCartPkg::lpfAcc_t sum;
    fmCartPkg::lpfAcc_t gain;

    // Enable divider
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)        divCnt <= '0;
        else if (i_sampleEn) divCnt <= divCnt + 1'b1;
    end

    assign tick = i_sampleEn && (divCnt == '0);

    // Circular index and fill level
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            index     <= '0;
            fillCount <= '0;
        end else if (tick) begin
            if (index == IDX_W'(PERIOD - 1)) index <= '0;
            else                              index <= index + 1'b1;
            if (fillCount != IDX_W'(PERIOD))  fillCount <= fillCount + 1'b1;
        end
    end

    // Window storage
    always_ff @(posedge CLK) begin
        if (tick) window[index] <= i_in;
    end

    // Sign extended operands
    fmCartPkg::lpfAcc_t inExt;
    fmCartPkg::lpfAcc_t oldExt;
    assign inExt  = fmCartPkg::lpfAcc_t'(i_in);
    assign oldExt = fmCartPkg::lpfAcc_t'(window[index]);

    // Running sum, drop displaced entry once full
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            sum <= '0;
        end else if (tick) begin
            if (fillCount == IDX_W'(PERIOD)) sum <= sum + inExt - oldExt;
            else                             sum <= sum + inExt;
        end
    end

    // Gain stage, floor divide
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) gain <= '0;
        else          gain <= sum >>> `FM_LPF_SHIFT;
    end

    satLimiter #(
        .IN_WIDTH  ($bits(fmCartPkg::lpfAcc_t)),
        .OUT_WIDTH ($bits(fmCartPkg::audio_t))
    ) uLimiter (
        .CLK     (CLK),
        .RESET_n (RESET_n),
        .i_in    (gain),
        .o_out   (o_out)
    );

    assert property (@(posedge CLK) disable iff (!RESET_n)
        fillCount <= IDX_W'(PERIOD));

endmodule

// File: hdl/cartRegisters.sv
/* Cartridge register block
   Decodes the slot bus, holds the I/O switch and SRAM enable registers,
   drives read-back and the synth chip select */

`include "fmCart_config.svh"

module cartRegisters (
    input  logic                CLK,
    input  logic                RESET_n,
    input  logic                i_slotReset_n,      // Bus reset, sampled
    input  fmCartPkg::busReq_t  i_bus,
    output fmCartPkg::busData_t o_busData,
    output logic                o_busDir_n,
    output logic                o_opllCs_n,
    output logic                o_opllWr_n,
    output logic                o_opllA0
);
    localparam fmCartPkg::addr_t   IO_BASE   = `FM_IO_BASE;
    localparam fmCartPkg::addr_t   MIO_BASE  = `FM_MIO_BASE;
    localparam fmCartPkg::addr_t   IOSW_ADDR = `FM_IOSW_ADDR;
    localparam fmCartPkg::addr_t   SRAM_BASE = `FM_SRAM_BASE;
    localparam fmCartPkg::addr_t   BANK_ADDR = `FM_SRAM_BANK_ADDR;
    localparam fmCartPkg::busData_t KEY0     = `FM_SRAM_KEY0;
    localparam fmCartPkg::busData_t KEY1     = `FM_SRAM_KEY1;

    fmCartPkg::busData_t ioSw;              // Bit 0 opens I/O ports
    fmCartPkg::busData_t sramBank [0:1];    // Key bytes
    logic                prevWrMem_n;

    // Memory strobes, slot qualified
    logic rdMem_n;
    logic wrMem_n;
    assign rdMem_n = i_bus.rd_n | i_bus.sltsl_n | i_bus.merq_n;
    assign wrMem_n = i_bus.wr_n | i_bus.sltsl_n | i_bus.merq_n;

    // Falling edge of write strobe
    logic detWrMem;
    assign detWrMem = prevWrMem_n & ~wrMem_n;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) prevWrMem_n <= 1'b1;
        else          prevWrMem_n <= wrMem_n;
    end

    // Address decode
    logic csIoSw_n;
    logic csSramBank_n;
    logic sramEn;
    logic csSram_n;
    assign csIoSw_n     = (i_bus.addr != IOSW_ADDR);
    assign csSramBank_n = (i_bus.addr[15:1] != BANK_ADDR[15:1]);
    assign sramEn       = (sramBank[0] == KEY0) && (sramBank[1] == KEY1);   // Both keys match
    assign csSram_n     = (i_bus.addr[15:13] != SRAM_BASE[15:13]) || !sramEn;

    // SRAM enable registers
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            sramBank[0] <= '0;
            sramBank[1] <= '0;
        end else if (!i_slotReset_n) begin
            sramBank[0] <= '0;
            sramBank[1] <= '0;
        end else if (detWrMem && !csSramBank_n) begin
            sramBank[i_bus.addr[0]] <= i_bus.wrData;    // A0 picks key byte
        end
    end

    // I/O switch register
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n)                      ioSw <= '0;
        else if (!i_slotReset_n)           ioSw <= '0;
        else if (detWrMem && !csIoSw_n)    ioSw <= i_bus.wrData;
    end

    // Read-back, one cycle behind the strobe
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            o_busDir_n <= 1'b1;
            o_busData  <= '0;
        end else if (!i_slotReset_n || rdMem_n) begin
            o_busDir_n <= 1'b1;             // Idle bus
            o_busData  <= '0;
        end else if (!csIoSw_n) begin
            o_busDir_n <= 1'b0;
            o_busData  <= ioSw;
        end else if (!csSram_n) begin
            // No storage behind the window, reads as zero
            o_busDir_n <= 1'b0;
            o_busData  <= '0;
        end else begin
            o_busDir_n <= 1'b1;
            o_busData  <= '0;
        end
    end

    // Synth select through I/O or memory
    logic csIo_n;
    logic csMemOpll_n;
    assign csIo_n      = (i_bus.addr[7:1] != IO_BASE[7:1]) || i_bus.iorq_n || !ioSw[0];
    assign csMemOpll_n = (i_bus.addr[15:1] != MIO_BASE[15:1]) || i_bus.merq_n || i_bus.sltsl_n;

    assign o_opllCs_n = csIo_n & csMemOpll_n;
    assign o_opllWr_n = i_bus.wr_n;
    assign o_opllA0   = i_bus.addr[0];      // Register or data port

    // Bus only turned around after a qualified read
    assert property (@(posedge CLK) disable iff (!RESET_n)
        !o_busDir_n |-> $past(!rdMem_n));

    // An I/O cycle only reaches the synth with the switch open
    assert property (@(posedge CLK) disable iff (!RESET_n)
        (!o_opllCs_n && !i_bus.iorq_n && i_bus.merq_n) |-> ioSw[0]);

endmodule

// File: hdl/fmMixer.sv
/* Sound mixer
   Centers melody and rhythm, filters each, sums with saturation */

`include "fmCart_config.svh"

module fmMixer (
    input  logic               CLK,
    input  logic               RESET_n,
    input  logic               i_slotReset_n,
    input  logic               i_sampleEn,
    input  fmCartPkg::sample_t i_mo,        // Melody
    input  fmCartPkg::sample_t i_ro,        // Rhythm
    output fmCartPkg::audio_t  o_sound
);
    localparam int                 W      = $bits(fmCartPkg::audio_t);
    localparam fmCartPkg::sample_t OFFSET = fmCartPkg::sample_t'(`FM_SAMPLE_OFFSET);

    fmCartPkg::audio_t moSigned;
    fmCartPkg::audio_t roSigned;
    fmCartPkg::audio_t lpfMo;
    fmCartPkg::audio_t lpfRo;
    fmCartPkg::audio_t mixSat;
    logic signed [W:0] mixSum;
    logic              audioReset_n;

    // Bus reset also clears the audio pipeline
    assign audioReset_n = RESET_n & i_slotReset_n;

    // Offset binary to two's complement
    assign moSigned = fmCartPkg::audio_t'(i_mo - OFFSET);
    assign roSigned = fmCartPkg::audio_t'(i_ro - OFFSET);

    movingAverageLpf uMoLpf (
        .CLK        (CLK),
        .RESET_n    (audioReset_n),
        .i_sampleEn (i_sampleEn),
        .i_in       (moSigned),
        .o_out      (lpfMo)
    );

    movingAverageLpf uRoLpf (
        .CLK        (CLK),
        .RESET_n    (audioReset_n),
        .i_sampleEn (i_sampleEn),
        .i_in       (roSigned),
        .o_out      (lpfRo)
    );

    // One extra bit for the sum
    assign mixSum = {lpfMo[W-1], lpfMo} + {lpfRo[W-1], lpfRo};

    satLimiter #(
        .IN_WIDTH  (W + 1),
        .OUT_WIDTH (W)
    ) uMixLimiter (
        .CLK     (CLK),
        .RESET_n (audioReset_n),
        .i_in    (mixSum),
        .o_out   (mixSat)
    );

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) o_sound <= '0;
        else          o_sound <= mixSat;   // Output stage
    end

endmodule

// File: hdl/cartridgeFm.sv
/* FM sound cartridge top
   Slot bus registers and synth select alongside the audio mixer */

module cartridgeFm (
    input  logic                CLK,
    input  logic                RESET_n,
    input  logic                i_slotReset_n,
    input  fmCartPkg::busReq_t  i_bus,
    input  logic                i_sampleEn,     // Synth sample rate
    input  fmCartPkg::sample_t  i_mo,
    input  fmCartPkg::sample_t  i_ro,
    output fmCartPkg::busData_t o_busData,
    output logic                o_busDir_n,
    output logic                o_opllCs_n,
    output logic                o_opllWr_n,
    output logic                o_opllA0,
    output fmCartPkg::audio_t   o_sound
);

    // Register side, toward the CPU and the synth
    cartRegisters uRegs (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .i_slotReset_n (i_slotReset_n),
        .i_bus         (i_bus),
        .o_busData     (o_busData),
        .o_busDir_n    (o_busDir_n),
        .o_opllCs_n    (o_opllCs_n),
        .o_opllWr_n    (o_opllWr_n),
        .o_opllA0      (o_opllA0)
    );

    // Audio side, synth DAC words in
    fmMixer uMixer (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .i_slotReset_n (i_slotReset_n),
        .i_sampleEn    (i_sampleEn),
        .i_mo          (i_mo),
        .i_ro          (i_ro),
        .o_sound       (o_sound)
    );

endmodule

// File: sim/tbCartridgeFm.sv
/* Testbench for the FM cartridge
   Table driven slot bus and audio checks under a cycle watchdog */

`include "fmCart_config.svh"

module tbCartridgeFm;
    localparam logic [2:0] OP_RD    = 3'd0;     // Memory read, fixed address
    localparam logic [2:0] OP_RDX   = 3'd1;     // Memory read, random undecoded address
    localparam logic [2:0] OP_WR    = 3'd2;     // Memory write
    localparam logic [2:0] OP_IOWR  = 3'd3;     // I/O write
    localparam logic [2:0] OP_SLOT  = 3'd4;     // Slot reset pulse
    localparam logic [2:0] OP_SOUND = 3'd5;     // Hold a sample pair

    localparam int N_STEPS       = 31;
    localparam int EN_GAP        = 2;           // Sample enable every other cycle
    // 18 taps times the divider, plus the pipeline and some margin
    localparam int SETTLE_CYCLES = EN_GAP * `FM_LPF_PERIOD * `FM_LPF_DIV + 8;
    localparam int CYCLE_LIMIT   = N_STEPS * 100 + SETTLE_CYCLES;

    typedef struct packed {
        logic [2:0]          op;
        fmCartPkg::addr_t    addr;
        fmCartPkg::busData_t data;              // Write data or expected read data
        logic                flag_n;            // Expected o_busDir_n or o_opllCs_n
        fmCartPkg::sample_t  mo;
        fmCartPkg::sample_t  ro;
        fmCartPkg::audio_t   sound;             // Expected o_sound
    } step_t;

    logic                CLK;
    logic                RESET_n;
    logic                i_slotReset_n;
    logic                i_sampleEn;
    fmCartPkg::busReq_t  i_bus;
    fmCartPkg::sample_t  i_mo;
    fmCartPkg::sample_t  i_ro;
    fmCartPkg::busData_t o_busData;
    logic                o_busDir_n;
    logic                o_opllCs_n;
    logic                o_opllWr_n;
    logic                o_opllA0;
    fmCartPkg::audio_t   o_sound;

    step_t steps [0:N_STEPS-1];
    int    errData;
    int    errSelect;
    int    errSound;
    int    errOther;
    int    seedInit;

    cartridgeFm DUT (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .i_slotReset_n (i_slotReset_n),
        .i_bus         (i_bus),
        .i_sampleEn    (i_sampleEn),
        .i_mo          (i_mo),
        .i_ro          (i_ro),
        .o_busData     (o_busData),
        .o_busDir_n    (o_busDir_n),
        .o_opllCs_n    (o_opllCs_n),
        .o_opllWr_n    (o_opllWr_n),
        .o_opllA0      (o_opllA0),
        .o_sound       (o_sound)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Upper half of memory, nothing decoded there
    function automatic fmCartPkg::addr_t randomUpperAddr();
        return {1'b1, 15'($urandom)};
    endfunction

    function automatic fmCartPkg::busReq_t idleBus();
        fmCartPkg::busReq_t req;
        req.addr    = randomUpperAddr();
        req.wrData  = 8'($urandom);
        req.rd_n    = 1'b1;
        req.wr_n    = 1'b1;
        req.iorq_n  = 1'b1;
        req.merq_n  = 1'b1;
        req.sltsl_n = 1'b1;
        return req;
    endfunction

    // One bus cycle, memory cycles carry the slot select
    function automatic fmCartPkg::busReq_t cycleBus(fmCartPkg::addr_t addr,
                                                   fmCartPkg::busData_t data,
                                                   logic isIo, logic isRead);
        fmCartPkg::busReq_t req;
        req         = idleBus();
        req.addr    = addr;
        req.wrData  = data;
        req.rd_n    = !isRead;
        req.wr_n    = isRead;
        req.iorq_n  = !isIo;
        req.merq_n  = isIo;
        req.sltsl_n = isIo;
        return req;
    endfunction

    function automatic step_t busStep(logic [2:0] op, fmCartPkg::addr_t addr,
                                      fmCartPkg::busData_t data, logic flag_n);
        step_t s;
        s        = '0;
        s.op     = op;
        s.addr   = addr;
        s.data   = data;
        s.flag_n = flag_n;
        return s;
    endfunction

    function automatic step_t soundStep(int mo, int ro, int sound);
        step_t s;
        s       = '0;
        s.op    = OP_SOUND;
        s.mo    = fmCartPkg::sample_t'(mo);
        s.ro    = fmCartPkg::sample_t'(ro);
        s.sound = fmCartPkg::audio_t'(sound);
        return s;
    endfunction

    task automatic buildTable();
        steps[0]  = busStep(OP_RD,   `FM_IOSW_ADDR, 8'h00, 1'b0);   // Switch cleared
        steps[1]  = busStep(OP_RDX,  16'h0000, 8'h00, 1'b1);
        steps[2]  = busStep(OP_IOWR, `FM_IO_BASE, 8'h12, 1'b1);     // Ports still closed
        steps[3]  = busStep(OP_IOWR, `FM_IO_BASE | 16'h0001, 8'h34, 1'b1);
        steps[4]  = busStep(OP_WR,   `FM_MIO_BASE, 8'h10, 1'b0);    // Memory path always open
        steps[5]  = busStep(OP_WR,   `FM_MIO_BASE | 16'h0001, 8'h20, 1'b0);
        steps[6]  = busStep(OP_WR,   `FM_IOSW_ADDR, 8'h01, 1'b1);
        steps[7]  = busStep(OP_RD,   `FM_IOSW_ADDR, 8'h01, 1'b0);
        steps[8]  = busStep(OP_IOWR, `FM_IO_BASE, 8'h0E, 1'b0);     // Ports now open
        steps[9]  = busStep(OP_IOWR, `FM_IO_BASE | 16'h0001, 8'h30, 1'b0);
        steps[10] = busStep(OP_WR,   `FM_MIO_BASE, 8'h0F, 1'b0);
        steps[11] = busStep(OP_RD,   `FM_SRAM_BASE, 8'h00, 1'b1);   // No key yet
        steps[12] = busStep(OP_WR,   `FM_SRAM_BANK_ADDR, `FM_SRAM_KEY0, 1'b1);
        steps[13] = busStep(OP_RD,   `FM_SRAM_BASE, 8'h00, 1'b1);   // Half a key
        steps[14] = busStep(OP_WR,   `FM_SRAM_BANK_ADDR | 16'h0001, `FM_SRAM_KEY1, 1'b1);
        steps[15] = busStep(OP_RD,   `FM_SRAM_BASE, 8'h00, 1'b0);
        steps[16] = busStep(OP_RD,   `FM_SRAM_BASE | 16'h1123, 8'h00, 1'b0);
        steps[17] = busStep(OP_WR,   `FM_SRAM_BANK_ADDR | 16'h0001, 8'h00, 1'b1);
        steps[18] = busStep(OP_RD,   `FM_SRAM_BASE, 8'h00, 1'b1);
        steps[19] = busStep(OP_WR,   `FM_SRAM_BANK_ADDR | 16'h0001, `FM_SRAM_KEY1, 1'b1);
        steps[20] = busStep(OP_RD,   `FM_SRAM_BASE, 8'h00, 1'b0);
        steps[21] = busStep(OP_WR,   `FM_SRAM_BANK_ADDR, `FM_SRAM_KEY0 ^ 8'h01, 1'b1);
        steps[22] = busStep(OP_RD,   `FM_SRAM_BASE, 8'h00, 1'b1);
        steps[23] = soundStep(592, 592, 180);           // 90 per channel
        steps[24] = busStep(OP_SLOT, 16'h0000, 8'h00, 1'b1);
        steps[25] = busStep(OP_RD,   `FM_IOSW_ADDR, 8'h00, 1'b0);
        steps[26] = busStep(OP_IOWR, `FM_IO_BASE, 8'h0E, 1'b1);     // Blocked again
        steps[27] = soundStep(600, 400, -27);           // 99 and -126
        steps[28] = soundStep(1023, 1023, 511);         // Both channels clip high
        steps[29] = soundStep(0, 0, -512);              // Both channels clip low
        steps[30] = soundStep(512, 512, 0);             // Midpoint is silence
    endtask

    task automatic checkBusData(string name, fmCartPkg::busData_t exp,
                                fmCartPkg::busData_t act);
        if (act !== exp) begin
            errData++;
            $display("ERR t=%0t %s expected %02h actual %02h", $time, name, exp, act);
        end
    endtask

    task automatic checkSelect(string name, logic exp, logic act);
        if (act !== exp) begin
            errSelect++;
            $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic checkSound(string name, fmCartPkg::audio_t exp, fmCartPkg::audio_t act);
        if (act !== exp) begin
            errSound++;
            $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic memRead(fmCartPkg::addr_t addr, fmCartPkg::busData_t expData,
                           logic expDir_n);
        @(posedge CLK);
        i_bus <= cycleBus(addr, 8'h00, 1'b0, 1'b1);
        @(posedge CLK);                                 // Read-back registers load
        @(negedge CLK);
        checkSelect("o_busDir_n", expDir_n, o_busDir_n);
        checkBusData("o_busData", expData, o_busData);
        @(posedge CLK);
        i_bus <= idleBus();
        @(posedge CLK);
        @(negedge CLK);
        checkSelect("o_busDir_n", 1'b1, o_busDir_n);    // Bus released again
        checkBusData("o_busData", 8'h00, o_busData);
    endtask

    task automatic busWrite(fmCartPkg::addr_t addr, fmCartPkg::busData_t data,
                            logic isIo, logic expCs_n);
        @(posedge CLK);
        i_bus <= cycleBus(addr, data, isIo, 1'b0);
        @(negedge CLK);                                 // Selects are combinational
        checkSelect("o_opllCs_n", expCs_n, o_opllCs_n);
        checkSelect("o_opllWr_n", 1'b0, o_opllWr_n);
        checkSelect("o_opllA0", addr[0], o_opllA0);
        @(posedge CLK);                                 // Falling strobe captured
        @(posedge CLK);
        i_bus <= idleBus();
        @(negedge CLK);
        checkSelect("o_opllCs_n", 1'b1, o_opllCs_n);
        checkSelect("o_opllWr_n", 1'b1, o_opllWr_n);    // Write strobe released
    endtask

    task automatic slotResetPulse();
        @(posedge CLK);
        i_slotReset_n <= 1'b0;
        repeat (2) @(posedge CLK);
        i_slotReset_n <= 1'b1;
        @(posedge CLK);
        @(negedge CLK);
        checkSound("o_sound", fmCartPkg::audio_t'(0), o_sound);    // Audio pipe cleared
    endtask

    task automatic applySound(fmCartPkg::sample_t mo, fmCartPkg::sample_t ro,
                              fmCartPkg::audio_t expSound);
        int n;
        @(posedge CLK);
        i_mo <= mo;
        i_ro <= ro;
        for (n = 0; n < SETTLE_CYCLES; n++) begin
            @(posedge CLK);
            i_sampleEn <= (n % EN_GAP == 0);
        end
        @(posedge CLK);
        i_sampleEn <= 1'b0;
        @(negedge CLK);
        checkSound("o_sound", expSound, o_sound);
    endtask

    initial begin : stimulus
        int i;
        seedInit      = $urandom(94);
        errData       = 0;
        errSelect     = 0;
        errSound      = 0;
        errOther      = 0;
        RESET_n       = 1'b0;
        i_slotReset_n = 1'b1;
        i_sampleEn    = 1'b0;
        i_mo          = fmCartPkg::sample_t'(`FM_SAMPLE_OFFSET);
        i_ro          = fmCartPkg::sample_t'(`FM_SAMPLE_OFFSET);
        i_bus         = idleBus();
        buildTable();

        repeat (2) @(posedge CLK);
        RESET_n <= 1'b1;
        @(negedge CLK);
        checkSelect("o_busDir_n", 1'b1, o_busDir_n);   // Idle after reset
        checkBusData("o_busData", 8'h00, o_busData);
        checkSelect("o_opllCs_n", 1'b1, o_opllCs_n);
        checkSound("o_sound", fmCartPkg::audio_t'(0), o_sound);

        for (i = 0; i < N_STEPS; i++) begin
            case (steps[i].op)
                OP_RD:    memRead(steps[i].addr, steps[i].data, steps[i].flag_n);
                OP_RDX:   memRead(randomUpperAddr(), steps[i].data, steps[i].flag_n);
                OP_WR:    busWrite(steps[i].addr, steps[i].data, 1'b0, steps[i].flag_n);
                OP_IOWR:  busWrite(steps[i].addr, steps[i].data, 1'b1, steps[i].flag_n);
                OP_SLOT:  slotResetPulse();
                OP_SOUND: applySound(steps[i].mo, steps[i].ro, steps[i].sound);
                default: begin
                    errOther++;
                    $display("Stimulus entry %0d has an unknown operation", i);
                end
            endcase
        end

        $display("Errors: %0d total (data %0d, select %0d, sound %0d, other %0d)",
                 errData + errSelect + errSound + errOther,
                 errData, errSelect, errSound, errOther);
        if (errData + errSelect + errSound + errOther == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Bounds the run if a task never returns
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: stimulus table not finished within %0d cycles", CYCLE_LIMIT);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: cartridgeFm.f
+incdir+hdl
hdl/fmCartPkg.sv
hdl/satLimiter.sv
hdl/movingAverageLpf.sv
hdl/cartRegisters.sv
hdl/fmMixer.sv
hdl/cartridgeFm.sv
sim/tbCartridgeFm.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the FM cartridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tbCartridgeFm \
    -Mdir obj_dir \
    -f cartridgeFm.f

./obj_dir/VtbCartridgeFm | tee sim.log

# Verdict comes from the simulation log
if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
